// ==== project.f ====
src/fpPkg.sv
src/fpAlignAdd.sv
src/fpSpecialCase.sv
src/fpRound.sv
src/fpAddSub.sv
verif/fpAddSubChecker.sv
verif/fpAddSubTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fpAddSub testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=fpAddSubSim

verilator --binary --timing -j 0 --top-module fpAddSubTb \
	-Mdir obj_dir -o "$BIN" -f project.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// ==== src/fpAddSub.sv ====
`default_nettype none

module fpAddSub import fpPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  fpT   opA,
	input  fpT   opB,
	input  logic subOp,
	output logic outValid,
	output fpT   result,
	output logic overflow,
	output logic invalid
);

	alignResT   alignComb;	// Significand path, combinational
	specialResT specialComb;	// Classifier, combinational
	alignResT   alignQ;	// Stage 1 registers
	specialResT specialQ;
	logic [1:0] validPipe;	// [0] stage 1, [1] output stage
	fpT         roundResult;
	logic       roundOverflow;
	logic       roundInvalid;

	// Parallel paths on the raw operands
	fpAlignAdd alignAdd0 (
		.opA      (opA),
		.opB      (opB),
		.subOp    (subOp),
		.alignRes (alignComb)
	);

	fpSpecialCase specialCase0 (
		.opA        (opA),
		.opB        (opB),
		.subOp      (subOp),
		.specialRes (specialComb)
	);

	// Stage 1, data loads every cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			alignQ <= '0;
			specialQ <= '0;
			validPipe[0] <= 1'b0;
		end else begin
			alignQ <= alignComb;
			specialQ <= specialComb;
			validPipe[0] <= inValid;
		end
	end

	// Rounding and merge
	fpRound round0 (
		.alignRes   (alignQ),
		.specialRes (specialQ),
		.result     (roundResult),
		.overflow   (roundOverflow),
		.invalid    (roundInvalid)
	);

	// Output stage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			result <= '0;
			overflow <= 1'b0;
			invalid <= 1'b0;
			validPipe[1] <= 1'b0;
		end else begin
			result <= roundResult;
			overflow <= roundOverflow;
			invalid <= roundInvalid;
			validPipe[1] <= validPipe[0];	// Two cycles after inValid
		end
	end

	assign outValid = validPipe[1];

endmodule

`default_nettype wire

// ==== src/fpAlignAdd.sv ====
`default_nettype none

module fpAlignAdd import fpPkg::*; (
	input  fpT       opA,
	input  fpT       opB,
	input  logic     subOp,
	output alignResT alignRes
);

	localparam int sigWidth = manWidth + 1;	// Hidden bit plus fraction
	localparam int sumWidth = sigWidth + 3;	// Plus guard, round, sticky
	localparam int lostWidth = 2 ** expWidth;	// Room for any shift amount
	localparam int alignWidth = sigWidth + 2 + lostWidth;
	localparam int lzWidth = $clog2(sumWidth + 1);

	// Position of the first set bit counted from the top
	function automatic int lzCount(input logic [sumWidth-1:0] v);
		int n;
		n = sumWidth;	// All zero
		for (int i = 0; i < sumWidth; i++) begin
			if (v[i]) begin
				n = sumWidth - 1 - i;	// Highest set bit wins last
			end
		end
		return n;
	endfunction

	logic                  signA, signB;	// Sign of A, effective sign of B
	logic [expWidth-1:0]   expA, expB;
	logic [sigWidth-1:0]   sigA, sigB;
	logic [fpWidth-2:0]    magA, magB;	// Flushed magnitudes for compare
	logic                  maxAB;
	logic [expWidth-1:0]   expL, expS;	// Larger / smaller exponent
	logic [sigWidth-1:0]   sigL, sigS;
	logic [expWidth-1:0]   expDiff;
	logic [alignWidth-1:0] aligned;	// Smaller significand after shift
	logic [sumWidth-1:0]   largeTerm, smallTerm;
	logic                  effSub;	// Signs differ, so subtract
	logic [sumWidth:0]     rawSum;	// One extra bit for carry
	logic                  zeroSum;
	logic [lzWidth-1:0]    lz;
	logic [sumWidth-1:0]   normSum;	// Hidden bit at top, GRS at bottom
	expT                   normE;

	// Unpack, subnormals become zero
	assign signA = opA[fpWidth-1];
	assign signB = opB[fpWidth-1] ^ subOp;	// Subtract flips B
	assign expA = opA[fpWidth-2 -: expWidth];
	assign expB = opB[fpWidth-2 -: expWidth];
	assign sigA = (expA == '0) ? '0 : {1'b1, opA[manWidth-1:0]};
	assign sigB = (expB == '0) ? '0 : {1'b1, opB[manWidth-1:0]};
	assign magA = (expA == '0) ? '0 : opA[fpWidth-2:0];
	assign magB = (expB == '0) ? '0 : opB[fpWidth-2:0];

	// Larger magnitude goes first
	assign maxAB = magB > magA;
	assign expL = maxAB ? expB : expA;
	assign expS = maxAB ? expA : expB;
	assign sigL = maxAB ? sigB : sigA;
	assign sigS = maxAB ? sigA : sigB;
	assign expDiff = expL - expS;	// Never negative after swap

	// Align smaller operand, shifted-out bits fold into sticky
	assign aligned = {sigS, 2'b00, {lostWidth{1'b0}}} >> expDiff;
	assign smallTerm = {aligned[alignWidth-1 -: sigWidth+2], |aligned[lostWidth-1:0]};
	assign largeTerm = {sigL, 3'b000};

	assign effSub = signA ^ signB;
	assign rawSum = effSub ? ({1'b0, largeTerm} - {1'b0, smallTerm}) :
	                         ({1'b0, largeTerm} + {1'b0, smallTerm});
	assign zeroSum = (rawSum == '0);	// Exact cancellation or two zeros
	assign lz = lzWidth'(lzCount(rawSum[sumWidth-1:0]));

	// Normalize
	always_comb begin
		normSum = '0;	// Default is flush to zero
		normE = '0;
		if (rawSum[sumWidth]) begin	// Carry out, shift right one
			normSum = {rawSum[sumWidth:2], rawSum[1] | rawSum[0]};
			normE = expT'(expL) + expT'(1);
		end else if (!zeroSum && (expT'(lz) < expT'(expL))) begin
			normSum = rawSum[sumWidth-1:0] << lz;	// Bring hidden bit to top
			normE = expT'(expL) - expT'(lz);
		end
		// Otherwise the result is below the normal range
	end

	// Pack for the rounding stage
	assign alignRes.zeroSum = zeroSum;
	assign alignRes.normE = normE;
	assign alignRes.normM = normSum[sumWidth-2 -: manWidth];
	assign alignRes.guardBit = normSum[2];
	assign alignRes.roundBit = normSum[1];
	assign alignRes.stickyBit = normSum[0];
	assign alignRes.signA = signA;
	assign alignRes.signB = signB;
	assign alignRes.subOp = subOp;
	assign alignRes.maxAB = maxAB;

endmodule

`default_nettype wire

// ==== src/fpPkg.sv ====
`default_nettype none

package fpPkg;

	localparam int expWidth = 5;	// Biased exponent bits
	localparam int manWidth = 10;	// Stored fraction bits
	localparam int fpWidth = 1 + expWidth + manWidth;	// Sign, exponent, fraction

	typedef logic [fpWidth-1:0] fpT;	// Packed half-precision word
	typedef logic [expWidth:0] expT;	// Exponent plus overflow bit
	typedef logic [manWidth-1:0] manT;	// Fraction without hidden bit

	localparam fpT qNaN = 16'h7E00;	// Canonical quiet NaN

	// Significand path result, handed to rounding
	typedef struct packed {
		logic zeroSum;	// Exact zero magnitude
		expT  normE;	// Normalized exponent, 0 means flush
		manT  normM;	// Normalized fraction
		logic guardBit;	// First bit below fraction
		logic roundBit;	// Second bit below fraction
		logic stickyBit;	// OR of everything further down
		logic signA;	// Sign of A
		logic signB;	// Effective sign of B
		logic subOp;	// Requested operation
		logic maxAB;	// B had the larger magnitude
	} alignResT;

	// Classifier result, overrides the computed value when set
	typedef struct packed {
		logic isSpecial;	// NaN or infinity involved
		fpT   value;	// Replacement result
		logic invalid;	// Inf minus inf
	} specialResT;

endpackage

`default_nettype wire

// ==== src/fpRound.sv ====
`default_nettype none

module fpRound import fpPkg::*; (
	input  alignResT   alignRes,
	input  specialResT specialRes,
	output fpT         result,
	output logic       overflow,
	output logic       invalid
);

	localparam logic [expWidth-1:0] expOnes = '1;	// All-ones exponent field
	localparam expT expLimit = expT'(expOnes);	// Exponent of inf and NaN

	logic                roundUp;	// Round to nearest even
	logic [manWidth:0]   roundUpM;	// Incremented fraction with carry
	manT                 roundM;
	logic                roundOf;	// Fraction carry into exponent
	expT                 roundE;
	logic                finalSign;
	logic                expOverflow;
	logic                flushZero;

	// Up when above half, or exactly half and LSB odd
	assign roundUp = alignRes.guardBit &
	                 (alignRes.roundBit | alignRes.stickyBit | alignRes.normM[0]);
	assign roundUpM = {1'b0, alignRes.normM} + 1'b1;
	assign roundM = roundUp ? roundUpM[manWidth-1:0] : alignRes.normM;
	assign roundOf = roundUp & roundUpM[manWidth];	// All-ones fraction wrapped
	assign roundE = alignRes.normE + expT'(roundOf);

	// Zero sum is -0 only if both effective signs are negative
	always_comb begin
		if (alignRes.zeroSum) begin
			finalSign = alignRes.signA & alignRes.signB;
		end else if (alignRes.maxAB) begin
			finalSign = alignRes.signB;	// B dominated
		end else begin
			finalSign = alignRes.signA;
		end
	end

	assign flushZero = alignRes.zeroSum | (alignRes.normE == '0);	// Includes underflow
	assign expOverflow = ~flushZero & (roundE >= expLimit);

	// Special case has priority over the computed value
	always_comb begin
		overflow = 1'b0;
		invalid = specialRes.invalid;
		if (specialRes.isSpecial) begin
			result = specialRes.value;
		end else if (flushZero) begin
			result = {finalSign, {(fpWidth-1){1'b0}}};
		end else if (expOverflow) begin
			result = {finalSign, expOnes, manT'(0)};	// Signed infinity
			overflow = 1'b1;
		end else begin
			result = {finalSign, roundE[expWidth-1:0], roundM};
		end
	end

endmodule

`default_nettype wire

// ==== src/fpSpecialCase.sv ====
`default_nettype none

module fpSpecialCase import fpPkg::*; (
	input  fpT         opA,
	input  fpT         opB,
	input  logic       subOp,
	output specialResT specialRes
);

	localparam logic [expWidth-1:0] expOnes = '1;	// Inf and NaN exponent

	logic                expMaxA, expMaxB;	// Exponent all ones
	logic                fracZeroA, fracZeroB;
	logic                nanA, nanB;
	logic                infA, infB;
	logic                signA, effSignB;
	logic                invalid;

	// Classify each operand
	assign expMaxA = (opA[fpWidth-2 -: expWidth] == expOnes);
	assign expMaxB = (opB[fpWidth-2 -: expWidth] == expOnes);
	assign fracZeroA = (opA[manWidth-1:0] == '0);
	assign fracZeroB = (opB[manWidth-1:0] == '0);
	assign nanA = expMaxA & ~fracZeroA;
	assign nanB = expMaxB & ~fracZeroB;
	assign infA = expMaxA & fracZeroA;
	assign infB = expMaxB & fracZeroB;

	assign signA = opA[fpWidth-1];
	assign effSignB = opB[fpWidth-1] ^ subOp;	// Sign B carries into the sum

	// Infinities pulling in opposite directions
	assign invalid = infA & infB & (signA ^ effSignB);

	// Pick the replacement value
	always_comb begin
		specialRes.isSpecial = nanA | nanB | infA | infB;
		specialRes.invalid = invalid;
		if (nanA | nanB | invalid) begin
			specialRes.value = qNaN;	// Any NaN input collapses here
		end else if (infA) begin
			specialRes.value = {signA, expOnes, manT'(0)};	// Same-sign inf pair lands here too
		end else if (infB) begin
			specialRes.value = {effSignB, expOnes, manT'(0)};
		end else begin
			specialRes.value = '0;	// Unused when not special
		end
	end

endmodule

`default_nettype wire

// ==== verif/fpAddSubChecker.sv ====
`default_nettype none

module fpAddSubChecker import fpPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  fpT   opA,
	input  fpT   opB,
	input  logic subOp,
	input  logic outValid,
	input  fpT   result,
	input  logic overflow,
	input  logic invalid,
	output int   valueErrors,
	output int   protocolErrors,
	output int   checkedCount,
	output int   pendingCount
);

	localparam int latency = 2;	// Sampling edges from inValid to outValid

	// One issued operation and what it should produce
	typedef struct packed {
		int   stamp;	// Edge count when inValid was seen
		fpT   a;
		fpT   b;
		logic sub;
		fpT   value;
		logic ovf;
		logic inv;
	} expectT;

	expectT pending[$];	// Oldest in flight first
	expectT got;
	expectT fresh;
	int     cycle;

	// Exact integer reference with values scaled by 2^25
	function automatic expectT predictResult(input fpT a, input fpT b, input logic sub);
		expectT e;
		logic   sa, sb, sgn;
		logic   nanA, nanB, infA, infB;
		int     ea, eb, p, ex;
		longint va, vb, sum, mag, keep, rem, half;
		e = '0;
		e.a = a;
		e.b = b;
		e.sub = sub;
		sa = a[15];
		sb = b[15] ^ sub;	// Effective sign of B
		ea = int'(a[14:10]);
		eb = int'(b[14:10]);
		nanA = (ea == 31) && (a[9:0] != '0);
		nanB = (eb == 31) && (b[9:0] != '0);
		infA = (ea == 31) && (a[9:0] == '0);
		infB = (eb == 31) && (b[9:0] == '0);
		if (nanA || nanB) begin
			e.value = 16'h7E00;
		end else if (infA && infB && (sa != sb)) begin
			e.value = 16'h7E00;	// Opposing infinities
			e.inv = 1'b1;
		end else if (infA) begin
			e.value = {sa, 5'h1F, 10'h000};
		end else if (infB) begin
			e.value = {sb, 5'h1F, 10'h000};
		end else begin
			// Subnormals count as zero
			va = (ea == 0) ? 64'sd0 : (longint'({1'b1, a[9:0]}) <<< ea);
			vb = (eb == 0) ? 64'sd0 : (longint'({1'b1, b[9:0]}) <<< eb);
			sum = (sa ? -va : va) + (sb ? -vb : vb);
			if (sum == 64'sd0) begin
				e.value = {sa & sb, 15'h0000};	// -0 only if both negative
			end else begin
				sgn = sum < 64'sd0;
				mag = sgn ? -sum : sum;
				p = 0;
				for (int i = 0; i < 64; i++) begin
					if (mag[i]) begin
						p = i;	// Leading one position
					end
				end
				ex = p - 10;	// Biased exponent and drop count
				if (ex <= 0) begin
					e.value = {sgn, 15'h0000};	// Flush below normal range
				end else begin
					keep = mag >>> ex;
					rem = mag & ((64'sd1 <<< ex) - 64'sd1);
					half = 64'sd1 <<< (ex - 1);
					if (rem > half || (rem == half && keep[0])) begin
						keep = keep + 64'sd1;	// Round to nearest even
					end
					if (keep == 64'sd2048) begin
						keep = 64'sd1024;	// Carry out of the fraction
						ex = ex + 1;
					end
					if (ex >= 31) begin
						e.value = {sgn, 5'h1F, 10'h000};
						e.ovf = 1'b1;
					end else begin
						e.value = {sgn, 5'(ex), 10'(keep)};
					end
				end
			end
		end
		return e;
	endfunction

	task automatic compareField(input string name, input logic [15:0] want,
	                            input logic [15:0] seen, input expectT op);
		if (seen !== want) begin
			$display("** Error: %s got 0x%h, expected 0x%h", name, seen, want);
			$display("   for opA 0x%h opB 0x%h subOp %0d issued at cycle %0d",
			         op.a, op.b, op.sub, op.stamp);
			valueErrors++;
		end
	endtask

	always @(posedge clk) begin
		if (!rstN) begin
			cycle = 0;
			pending.delete();
			valueErrors = 0;
			protocolErrors = 0;
			checkedCount = 0;
			pendingCount = 0;
		end else begin
			if (cycle == 0 && (outValid !== 1'b0 || overflow !== 1'b0 ||
			                   invalid !== 1'b0 || result !== '0)) begin
				$display("Outputs were not cleared by reset");
				protocolErrors++;
			end
			cycle++;
			// Anything past its slot never showed up
			while (pending.size() > 0 && pending[0].stamp + latency < cycle) begin
				$display("Missing outValid for operation issued at cycle %0d", pending[0].stamp);
				protocolErrors++;
				void'(pending.pop_front());
			end
			if (outValid) begin
				if (pending.size() == 0) begin
					$display("Unexpected outValid at cycle %0d with nothing in flight", cycle);
					protocolErrors++;
				end else begin
					got = pending.pop_front();
					if (got.stamp + latency != cycle) begin
						$display("outValid at cycle %0d came early for operation from cycle %0d",
						         cycle, got.stamp);
						protocolErrors++;
					end
					compareField("result", got.value, result, got);
					compareField("overflow", 16'(got.ovf), 16'(overflow), got);
					compareField("invalid", 16'(got.inv), 16'(invalid), got);
					checkedCount++;
				end
			end
			if (inValid) begin
				fresh = predictResult(opA, opB, subOp);
				fresh.stamp = cycle;
				pending.push_back(fresh);
			end
			pendingCount = pending.size();
		end
	end

endmodule

`default_nettype wire

// ==== verif/fpAddSubTb.sv ====
`default_nettype none

module fpAddSubTb import fpPkg::*; ();

	typedef struct packed {
		fpT   a;
		fpT   b;
		logic sub;
	} opT;

	localparam int randomOps = 3000;
	localparam int cornerCount = 30;
	localparam int totalOps = randomOps + cornerCount;
	localparam int cycleLimit = 2 * totalOps + 50;	// Whole run incl. reset and drain

	localparam opT cornerOps [cornerCount] = '{
		{16'h3C00, 16'h3C00, 1'b1},	// x - x
		{16'h8000, 16'h8000, 1'b0},	// -0 + -0
		{16'h0001, 16'h8001, 1'b0},	// Subnormals as signed zeros
		{16'h8005, 16'h8003, 1'b0},
		{16'h8000, 16'h0000, 1'b1},
		{16'hBC00, 16'h3C00, 1'b0},	// Opposite signs cancel
		{16'h3C00, 16'h1000, 1'b0},	// Tie, LSB already even
		{16'h3C01, 16'h1000, 1'b0},	// Tie, odd LSB goes up
		{16'h3FFF, 16'h1000, 1'b0},	// All-ones fraction bumps exponent
		{16'h3C00, 16'h1000, 1'b1},
		{16'h7BFF, 16'h7BFF, 1'b0},	// Max finite doubled
		{16'hFBFF, 16'hFBFF, 1'b0},
		{16'h7BFF, 16'h4C00, 1'b0},	// Tie above max finite
		{16'h7BFF, 16'h4C01, 1'b0},
		{16'h7BFF, 16'h4BFF, 1'b0},	// Just under the tie
		{16'h7BFF, 16'hCC00, 1'b1},
		{16'h7E00, 16'h3C00, 1'b0},	// NaN in
		{16'h3C00, 16'h7C01, 1'b1},
		{16'hFE00, 16'hFC00, 1'b0},
		{16'h7C00, 16'h7C00, 1'b1},	// inf - inf
		{16'h7C00, 16'hFC00, 1'b0},
		{16'hFC00, 16'hFC00, 1'b1},
		{16'h7C00, 16'h3C00, 1'b0},	// Inf with finite
		{16'h3C00, 16'h7C00, 1'b1},
		{16'h4000, 16'hFC00, 1'b1},
		{16'h7C00, 16'h7C00, 1'b0},	// Same-sign infinities
		{16'h0401, 16'h0400, 1'b1},	// Tiny difference flushes
		{16'h0400, 16'h0401, 1'b1},
		{16'h0800, 16'h0400, 1'b1},	// Lands on min normal
		{16'h7BFF, 16'h0400, 1'b0}	// Large exponent gap
	};

	logic        clk;
	logic        rstN;
	logic        inValid;
	fpT          opA;
	fpT          opB;
	logic        subOp;
	logic        outValid;
	fpT          result;
	logic        overflow;
	logic        invalid;
	logic [31:0] rngState;
	int          cycleCount = 0;
	int          valueErrors;
	int          protocolErrors;
	int          checkedCount;
	int          pendingCount;

	fpAddSub uut (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.opA      (opA),
		.opB      (opB),
		.subOp    (subOp),
		.outValid (outValid),
		.result   (result),
		.overflow (overflow),
		.invalid  (invalid)
	);

	fpAddSubChecker checker0 (
		.clk            (clk),
		.rstN           (rstN),
		.inValid        (inValid),
		.opA            (opA),
		.opB            (opB),
		.subOp          (subOp),
		.outValid       (outValid),
		.result         (result),
		.overflow       (overflow),
		.invalid        (invalid),
		.valueErrors    (valueErrors),
		.protocolErrors (protocolErrors),
		.checkedCount   (checkedCount),
		.pendingCount   (pendingCount)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;	// 40 unit period

	// Run bound
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic driveRandom(output logic fired);
		fpT a;
		fpT b;
		rngState = nextRandom(rngState);
		fired = rngState[7:0] < 8'd205;	// About 80 percent
		a = rngState[23:8];
		rngState = nextRandom(rngState);
		b = rngState[15:0];
		if (rngState[18:16] < 3'd3) begin
			b[14:10] = a[14:10];	// Equal exponents, more cancellation
		end
		inValid <= fired;
		opA <= a;
		opB <= b;
		subOp <= rngState[31];
	endtask

	initial begin
		int   issued;
		logic fired;
		issued = 0;
		rngState = 32'd2660;
		rstN <= 1'b0;
		inValid <= 1'b0;
		opA <= '0;
		opB <= '0;
		subOp <= 1'b0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		while (issued < randomOps) begin
			@(posedge clk);
			driveRandom(fired);
			if (fired) begin
				issued++;
			end
		end
		// Corners back to back
		for (int i = 0; i < cornerCount; i++) begin
			@(posedge clk);
			inValid <= 1'b1;
			opA <= cornerOps[i].a;
			opB <= cornerOps[i].b;
			subOp <= cornerOps[i].sub;
		end
		@(posedge clk);
		inValid <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		while (pendingCount != 0) begin
			@(negedge clk);
		end
		if (checkedCount != totalOps) begin
			$display("Only %0d of %0d operations produced a result", checkedCount, totalOps);
		end
		$display("Checked %0d results: %0d value errors, %0d protocol errors",
		         checkedCount, valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0 && checkedCount == totalOps) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
